// ==== sim.f ====
source/dsp_sample_pkg.sv
source/dsp_instr_pkg.sv
source/lut_if.sv
source/delay_if.sv
source/lut_unit.sv
source/delay_unit.sv
source/dsp_core.sv
source/dsp_pipeline.sv
sim/dsp_pipeline_properties.sv
sim/dsp_pipeline_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module dsp_pipeline_tb \
	&& ./obj_dir/Vdsp_pipeline_tb \
	|| exit 1

// ==== sim/dsp_pipeline_tb.sv ====
module dsp_pipeline_tb;
	import dsp_sample_pkg::*;
	import dsp_instr_pkg::*;

	localparam int n_blocks = 8;
	localparam int addr_w = $clog2(n_blocks);
	localparam int n_samples = 78;
	localparam int watchdog_cycles = n_samples * 40 + 400;

	logic clk;
	logic arst_n;
	logic full_reset;
	sample_t in_sample;
	logic in_valid;
	logic ready;
	sample_t out_sample;
	logic out_valid;
	logic instr_write;
	logic [addr_w-1:0] instr_addr;
	instr_t instr_val;
	logic instr_write_ack;
	logic alloc_delay;
	logic [DELAY_DEPTH_W-1:0] delay_len;
	logic error;

	integer seed = 32'hb9e5_0100;
	instr_t prog [n_blocks];
	sample_t dly_q [$];
	sample_t exp_q [$];
	int model_len;
	logic model_err;
	int n_sent;
	int n_done;
	logic [11:0] gains [3];

	dsp_pipeline #(
		.n_blocks(n_blocks)
	) i_dsp_pipeline (.*);

	always #5 clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (exp !== act)
			report_failure($sformatf("Fail at time %0t: %s expected %0d, got %0d",
				$time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
			report_failure($sformatf("Fail at time %0t: %s expected %b, got %b",
				$time, name, exp, act));
	endtask

	function automatic int clamp16(input int v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return v;
	endfunction

	// runs the whole program on one sample, including the delay line history.
	function automatic sample_t model_sample(input sample_t x);
		int acc;
		int base;
		int n;
		instr_t w;
		acc = x;
		for (int i = 0; i < n_blocks; i++) begin
			w = prog[i];
			case (w.op_imm.op)
				NOP: ;
				GAIN: acc = clamp16((acc * int'($signed(w.op_imm.imm[11:0]))) >>> 8);
				LUT: begin
					base = int'(sample_t'({acc[15:8], 8'h00}));
					if (w.op_lut.handle == LUT_ABS)
						acc = clamp16((base < 0) ? -base : base);
					else
						acc = (base > 0) ? base : 0;
				end
				DELAY: begin
					n = dly_q.size();
					dly_q.push_back(sample_t'(acc));
					if (model_len != 0)
						acc = (n < model_len) ? 0 : int'(dly_q[n - model_len]);
				end
				MIX: acc = clamp16(acc + int'(x));
				default: model_err = 1'b1;
			endcase
		end
		return sample_t'(acc);
	endfunction

	function automatic instr_t make_instr(input opcode_t op, input logic [11:0] imm);
		instr_t w;
		w.op_imm.op = op;
		w.op_imm.imm = {1'b0, imm};
		return w;
	endfunction

	task automatic check_instr_ack(input logic [addr_w-1:0] addr);
		string name;
		name = $sformatf("instr_write_ack (slot %0d)", addr);
		check_flag(name, 1'b1, instr_write_ack);
		@(posedge clk);
		#1;
		check_flag(name, 1'b0, instr_write_ack);
	endtask

	// every output must be back before the core counts as idle.
	task automatic wait_idle();
		in_valid = 1'b0;
		wait (n_done == n_sent);
		@(posedge clk);
		#1;
		check_flag("ready", 1'b1, ready);
	endtask

	task automatic send_sample(input sample_t x);
		in_sample = x;
		in_valid = 1'b1;
		@(negedge clk);
		while (!ready)
			@(negedge clk);
		exp_q.push_back(model_sample(x));
		n_sent++;
		@(posedge clk);
		#1;
	endtask

	task automatic send_random(input int count);
		for (int i = 0; i < count; i++)
			send_sample(sample_t'($random(seed)));
	endtask

	task automatic write_instr(input logic [addr_w-1:0] addr, input instr_t w);
		wait_idle();
		instr_write = 1'b1;
		instr_addr = addr;
		instr_val = w;
		@(posedge clk);
		#1;
		instr_write = 1'b0;
		prog[addr] = w;
		check_instr_ack(addr);
	endtask

	task automatic alloc_line(input logic [DELAY_DEPTH_W-1:0] len);
		wait_idle();
		alloc_delay = 1'b1;
		delay_len = len;
		@(posedge clk);
		#1;
		alloc_delay = 1'b0;
		dly_q.delete();
		model_len = len;
	endtask

	task automatic pulse_full_reset();
		wait_idle();
		full_reset = 1'b1;
		@(posedge clk);
		#1;
		full_reset = 1'b0;
		for (int i = 0; i < n_blocks; i++)
			prog[i] = '0;
		dly_q.delete();
		model_len = delay_len;
		model_err = 1'b0;
		check_flag("error", 1'b0, error);
	endtask

	always @(negedge clk) begin
		if (arst_n && out_valid) begin
			if (exp_q.size() == 0) begin
				report_failure("out_valid pulsed with no sample in flight");
			end else begin
				check_sample("out_sample", exp_q.pop_front(), out_sample);
				check_flag("error", model_err, error);
				n_done++;
			end
		end
	end

	initial begin
		#(watchdog_cycles * 10);
		report_failure("Timeout: the pipeline hung waiting for outputs");
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		full_reset = 1'b0;
		in_sample = '0;
		in_valid = 1'b0;
		instr_write = 1'b0;
		instr_addr = '0;
		instr_val = '0;
		alloc_delay = 1'b0;
		delay_len = '0;
		model_len = 0;
		model_err = 1'b0;
		n_sent = 0;
		n_done = 0;
		gains = '{12'h180, 12'he00, 12'h800};
		for (int i = 0; i < n_blocks; i++)
			prog[i] = '0;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;

		send_random(8);

		write_instr(1, make_instr(MIX, 12'h000));
		for (int g = 0; g < 3; g++) begin
			write_instr(0, make_instr(GAIN, gains[g]));
			send_sample(16'sh7fff);
			send_sample(sample_t'(16'h8000));
			send_sample(-16'sd1);
			send_random(3);
		end

		write_instr(1, make_instr(NOP, 12'h000));
		write_instr(0, make_instr(LUT, 12'(LUT_RECT)));
		send_sample(sample_t'(16'h8000));
		send_random(7);
		write_instr(0, make_instr(LUT, 12'(LUT_ABS)));
		send_sample(sample_t'(16'h8000));
		send_random(7);

		alloc_line(5);
		write_instr(0, make_instr(DELAY, 12'h000));
		send_random(12);
		alloc_line(3);
		send_random(8);

		write_instr(1, make_instr(opcode_t'(3'd6), 12'h000));
		check_flag("error", 1'b0, error);
		send_random(1);
		wait_idle();
		check_flag("error", 1'b1, error);
		pulse_full_reset();
		send_random(10);

		// the delay line must start empty again after full_reset.
		write_instr(0, make_instr(DELAY, 12'h000));
		send_random(5);

		wait_idle();
		if (n_done == n_samples) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			report_failure($sformatf("only %0d of %0d outputs arrived", n_done, n_samples));
		end
	end

endmodule

// ==== sim/dsp_pipeline_properties.sv ====
module dsp_pipeline_properties (
	input logic clk,
	input logic arst_n,
	input logic full_reset,
	input logic in_valid,
	input logic ready,
	input logic out_valid,
	input logic instr_write,
	input logic instr_write_ack,
	input logic error
);

	logic honored;

	assign honored = instr_write && ready && !in_valid;

	assert property (@(posedge clk) disable iff (!arst_n || full_reset)
		(in_valid && ready) |=> !ready)
		else $error("ready stayed high after a sample was accepted");

	// once a sample is in flight, ready returns only after out_valid.
	assert property (@(posedge clk) disable iff (!arst_n || full_reset)
		(!ready && !out_valid) |=> !ready)
		else $error("ready rose before out_valid had pulsed");

	// the ack is a register of the honored write and nothing else.
	assert property (@(posedge clk) disable iff (!arst_n || full_reset)
		honored |=> instr_write_ack)
		else $error("instr_write_ack missing after an honored write");

	assert property (@(posedge clk) disable iff (!arst_n || full_reset)
		!honored |=> !instr_write_ack)
		else $error("instr_write_ack without an honored write");

	assert property (@(posedge clk) disable iff (!arst_n)
		$fell(error) |-> $past(full_reset))
		else $error("error fell without a reset");

endmodule

bind dsp_pipeline dsp_pipeline_properties i_dsp_pipeline_properties (
	.clk            (clk),
	.arst_n         (arst_n),
	.full_reset     (full_reset),
	.in_valid       (in_valid),
	.ready          (ready),
	.out_valid      (out_valid),
	.instr_write    (instr_write),
	.instr_write_ack(instr_write_ack),
	.error          (error)
);

// ==== source/dsp_pipeline.sv ====
module dsp_pipeline #(
	parameter int n_blocks = 8
) (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic                                     full_reset,
	input  dsp_sample_pkg::sample_t                  in_sample,
	input  logic                                     in_valid,
	output logic                                     ready,
	output dsp_sample_pkg::sample_t                  out_sample,
	output logic                                     out_valid,
	input  logic                                     instr_write,
	input  logic [$clog2(n_blocks)-1:0]              instr_addr,
	input  dsp_instr_pkg::instr_t                    instr_val,
	output logic                                     instr_write_ack,
	input  logic                                     alloc_delay,
	input  logic [dsp_sample_pkg::DELAY_DEPTH_W-1:0] delay_len,
	output logic                                     error
);

	lut_if lut_bus ();
	delay_if dly_bus ();

	dsp_core #(
		.n_blocks(n_blocks)
	) i_dsp_core (
		.clk            (clk),
		.arst_n         (arst_n),
		.full_reset     (full_reset),
		.in_sample      (in_sample),
		.in_valid       (in_valid),
		.ready          (ready),
		.out_sample     (out_sample),
		.out_valid      (out_valid),
		.instr_write    (instr_write),
		.instr_addr     (instr_addr),
		.instr_val      (instr_val),
		.instr_write_ack(instr_write_ack),
		.alloc_delay    (alloc_delay),
		.delay_len      (delay_len),
		.error          (error),
		.lut            (lut_bus.core),
		.dly            (dly_bus.core)
	);

	lut_unit i_lut_unit (
		.clk   (clk),
		.arst_n(arst_n),
		.lut   (lut_bus.unit)
	);

	delay_unit i_delay_unit (
		.clk   (clk),
		.arst_n(arst_n),
		.dly   (dly_bus.unit)
	);

endmodule

// ==== source/dsp_core.sv ====
module dsp_core #(
	parameter int n_blocks = 8
) (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic                                     full_reset,
	input  dsp_sample_pkg::sample_t                  in_sample,
	input  logic                                     in_valid,
	output logic                                     ready,
	output dsp_sample_pkg::sample_t                  out_sample,
	output logic                                     out_valid,
	input  logic                                     instr_write,
	input  logic [$clog2(n_blocks)-1:0]              instr_addr,
	input  dsp_instr_pkg::instr_t                    instr_val,
	output logic                                     instr_write_ack,
	input  logic                                     alloc_delay,
	input  logic [dsp_sample_pkg::DELAY_DEPTH_W-1:0] delay_len,
	output logic                                     error,
	lut_if.core                                      lut,
	delay_if.core                                    dly
);
	import dsp_sample_pkg::*;
	import dsp_instr_pkg::*;

	localparam int addr_w = $clog2(n_blocks);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_WAIT,
		S_OUT
	} state_t;

	state_t state;
	logic [addr_w-1:0] slot;
	instr_t imem [n_blocks];
	instr_t cur;
	sample_t acc;
	sample_t sample_q;
	logic host_ok;
	logic wait_op;
	logic undef_op;
	logic slot_done;
	logic last_slot;
	logic signed [11:0] gain_imm;
	logic signed [27:0] gain_prod;
	logic signed [16:0] mix_sum;

	assign ready = (state == S_IDLE);
	assign out_valid = (state == S_OUT);
	assign out_sample = acc;
	assign host_ok = ready && !in_valid;

	assign cur = imem[slot];
	assign wait_op = (cur.op_imm.op == LUT) || (cur.op_imm.op == DELAY);
	assign undef_op = (cur.op_imm.op > MIX);
	assign last_slot = (slot == addr_w'(n_blocks - 1));
	assign slot_done = ((state == S_RUN) && !wait_op) ||
		((state == S_WAIT) && (lut.valid || dly.valid));

	assign gain_imm = cur.op_imm.imm[11:0];
	assign gain_prod = acc * gain_imm;
	assign mix_sum = acc + sample_q;

	assign lut.req = (state == S_RUN) && (cur.op_lut.op == LUT);
	assign lut.handle = cur.op_lut.handle;
	assign lut.arg = acc;

	// full_reset also empties the delay line through a forced alloc.
	assign dly.req = (state == S_RUN) && (cur.op_imm.op == DELAY);
	assign dly.write_data = acc;
	assign dly.alloc = full_reset || (alloc_delay && host_ok);
	assign dly.alloc_len = delay_len;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < n_blocks; i++)
				imem[i] <= '0;
		end else if (full_reset) begin
			for (int i = 0; i < n_blocks; i++)
				imem[i] <= '0;
		end else if (instr_write && host_ok) begin
			imem[instr_addr] <= instr_val;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			slot <= '0;
			error <= 1'b0;
			instr_write_ack <= 1'b0;
		end else if (full_reset) begin
			state <= S_IDLE;
			slot <= '0;
			error <= 1'b0;
			instr_write_ack <= 1'b0;
		end else begin
			instr_write_ack <= instr_write && host_ok;
			if ((state == S_RUN) && undef_op)
				error <= 1'b1;
			case (state)
				S_IDLE: begin
					if (in_valid) begin
						state <= S_RUN;
						slot <= '0;
					end
				end
				S_OUT: state <= S_IDLE;
				default: begin
					if (slot_done) begin
						if (last_slot) begin
							state <= S_OUT;
						end else begin
							slot <= slot + 1'b1;
							state <= S_RUN;
						end
					end else if (state == S_RUN) begin
						state <= S_WAIT;
					end
				end
			endcase
		end
	end

	// acc starts as the accepted sample and then takes the result of each slot in turn.
	always_ff @(posedge clk) begin
		if ((state == S_IDLE) && in_valid) begin
			acc <= in_sample;
			sample_q <= in_sample;
		end else if (state == S_RUN) begin
			if (cur.op_imm.op == GAIN)
				acc <= saturate(gain_prod >>> 8);
			else if (cur.op_imm.op == MIX)
				acc <= saturate(mix_sum);
		end else if (state == S_WAIT) begin
			if (lut.valid)
				acc <= lut.data;
			else if (dly.valid)
				acc <= dly.read_data;
		end
	end

endmodule

// ==== source/delay_unit.sv ====
module delay_unit (
	input logic clk,
	input logic arst_n,
	delay_if.unit dly
);
	import dsp_sample_pkg::*;

	localparam int depth = 1 << DELAY_DEPTH_W;

	sample_t mem [depth];
	logic [DELAY_DEPTH_W-1:0] wr_ptr;
	logic [DELAY_DEPTH_W-1:0] len;
	logic [DELAY_DEPTH_W-1:0] fill;
	logic access;

	// alloc wins over a request arriving in the same cycle.
	assign access = dly.req && !dly.alloc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			len <= '0;
			fill <= '0;
			dly.valid <= 1'b0;
		end else begin
			dly.valid <= dly.req;
			if (dly.alloc) begin
				len <= dly.alloc_len;
				fill <= '0;
			end else if (access) begin
				wr_ptr <= wr_ptr + 1'b1;
				if (fill != '1)
					fill <= fill + 1'b1;
			end
		end
	end

	// the fill count hides stale contents left over from an earlier allocation.
	always_ff @(posedge clk) begin
		if (access) begin
			mem[wr_ptr] <= dly.write_data;
			if (len == '0)
				dly.read_data <= dly.write_data;
			else if (fill < len)
				dly.read_data <= '0;
			else
				dly.read_data <= mem[wr_ptr - len];
		end
	end

endmodule

// ==== source/lut_unit.sv ====
module lut_unit (
	input logic clk,
	input logic arst_n,
	lut_if.unit lut
);
	import dsp_sample_pkg::*;

	sample_t rect_tab [256];
	sample_t abs_tab [256];
	logic [7:0] idx;

	assign idx = lut.arg[15:8];

	// tables are loaded once at reset and are read only afterwards.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 256; i++) begin
				rect_tab[i] <= lut_entry(LUT_RECT, 8'(i));
				abs_tab[i] <= lut_entry(LUT_ABS, 8'(i));
			end
			lut.valid <= 1'b0;
		end else begin
			lut.valid <= lut.req;
		end
	end

	always_ff @(posedge clk) begin
		if (lut.req) begin
			if (lut.handle == LUT_ABS)
				lut.data <= abs_tab[idx];
			else
				lut.data <= rect_tab[idx];
		end
	end

endmodule

// ==== source/delay_if.sv ====
interface delay_if;
	import dsp_sample_pkg::*;

	logic                     req;
	sample_t                  write_data;
	logic                     alloc;
	logic [DELAY_DEPTH_W-1:0] alloc_len;
	sample_t                  read_data;
	logic                     valid;

	// a req is a read of the delayed sample followed by a write of write_data.
	modport core (
		output req, write_data, alloc, alloc_len,
		input  read_data, valid
	);

	modport unit (
		input  req, write_data, alloc, alloc_len,
		output read_data, valid
	);

endinterface

// ==== source/lut_if.sv ====
interface lut_if;
	import dsp_sample_pkg::*;

	logic        req;
	lut_handle_t handle;
	sample_t     arg;
	sample_t     data;
	logic        valid;

	// valid follows req by exactly one cycle.
	modport core (
		output req, handle, arg,
		input  data, valid
	);

	modport unit (
		input  req, handle, arg,
		output data, valid
	);

endinterface

// ==== source/dsp_instr_pkg.sv ====
package dsp_instr_pkg;

	// codes 5 to 7 are undefined and execute as NOP with the error flag set.
	typedef enum logic [2:0] {
		NOP   = 3'd0,
		GAIN  = 3'd1,
		LUT   = 3'd2,
		DELAY = 3'd3,
		MIX   = 3'd4
	} opcode_t;

	// imm[11:0] is a signed Q4.8 gain.
	typedef struct packed {
		opcode_t     op;
		logic [12:0] imm;
	} op_imm_t;

	typedef struct packed {
		opcode_t                     op;
		logic [11:0]                 unused;
		dsp_sample_pkg::lut_handle_t handle;
	} op_lut_t;

	typedef union packed {
		op_imm_t op_imm;
		op_lut_t op_lut;
	} instr_t;

endpackage

// ==== source/dsp_sample_pkg.sv ====
package dsp_sample_pkg;

	typedef logic signed [15:0] sample_t;

	localparam sample_t SAMPLE_MAX = 16'sh7fff;
	localparam sample_t SAMPLE_MIN = sample_t'(16'h8000);

	// table select for the lookup unit.
	typedef enum logic {
		LUT_RECT = 1'b0,
		LUT_ABS  = 1'b1
	} lut_handle_t;

	// one delay buffer of 1024 samples.
	localparam int DELAY_DEPTH_W = 10;

	function automatic sample_t saturate(input logic signed [31:0] v);
		if (v > SAMPLE_MAX)
			return SAMPLE_MAX;
		if (v < SAMPLE_MIN)
			return SAMPLE_MIN;
		return v[15:0];
	endfunction

	// tables only see the upper 8 bits of the argument.
	function automatic sample_t lut_entry(input lut_handle_t handle, input logic [7:0] idx);
		sample_t base;
		logic signed [31:0] wide;
		base = {idx, 8'h00};
		wide = base;
		if (handle == LUT_ABS)
			return saturate((base < 0) ? -wide : wide);
		return (base > 0) ? base : '0;
	endfunction

endpackage
